/* compile.f */
ntt_pkg.sv
ntt_add_sub_mod.sv
ntt_mult_reduction.sv
ntt_butterfly.sv
ntt_apb_regs.sv
ntt_butterfly_top.sv
tb_ntt_butterfly.sv

/* ntt_add_sub_mod.sv */
// ============================
// Registered modular add or subtract, one cycle
// Both operands must already be below q
// ============================
`default_nettype none

module ntt_add_sub_mod
    import ntt_pkg::*;
(
    input  wire    clk,
    input  wire    reset_n,
    input  logic   sub_i,
    input  coeff_t opa_i,
    input  coeff_t opb_i,
    output coeff_t res_o
);

    // One spare bit holds the carry or the borrow
    logic [COEFF_W:0] sum;
    logic [COEFF_W:0] diff;
    logic [COEFF_W:0] sum_corr;
    logic [COEFF_W:0] diff_corr;
    coeff_t           res_d;

    always_comb begin
        sum       = {1'b0, opa_i} + {1'b0, opb_i};
        diff      = {1'b0, opa_i} - {1'b0, opb_i};
        sum_corr  = sum - {1'b0, NTT_Q};
        diff_corr = diff + {1'b0, NTT_Q};

        if (sub_i) begin
            // Borrow out of the top bit means u < v
            res_d = diff[COEFF_W] ? diff_corr[COEFF_W-1:0] : diff[COEFF_W-1:0];
        end else begin
            res_d = (sum >= {1'b0, NTT_Q}) ? sum_corr[COEFF_W-1:0] : sum[COEFF_W-1:0];
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            res_o <= '0;
        end else begin
            res_o <= res_d;
        end
    end

endmodule

`default_nettype wire

/* ntt_apb_regs.sv */
// ============================
// APB3 register block, zero wait states
// Operand writes at or above q are refused with pslverr
// ============================
`default_nettype none

module ntt_apb_regs
    import ntt_pkg::*;
(
    input  wire       clk,
    input  wire       reset_n,
    input  apb_addr_t paddr_i,
    input  logic      psel_i,
    input  logic      penable_i,
    input  logic      pwrite_i,
    input  apb_data_t pwdata_i,
    output apb_data_t prdata_o,
    output logic      pready_o,
    output logic      pslverr_o,
    output mode_t     mode_o,
    output logic      accumulate_o,
    output coeff_t    opu_o,
    output coeff_t    opv_o,
    output coeff_t    opw_o,
    output logic      issue_o,
    input  coeff_t    res0_i,
    input  coeff_t    res1_i
);

    logic      access, wr_en, rd_en;
    logic      addr_mapped, addr_operand, operand_bad, wr_reject;
    logic      cmd_issue, capture, busy;
    logic      acc_q, done_q;
    mode_t     mode_q;
    coeff_t    opu_q, opv_q, opw_q, res0_q, res1_q;
    apb_data_t rdata;

    // One bit per cycle an operation spends in the butterfly
    logic [BFLY_LATENCY-1:0] valid_pipe;

    // ============================
    // Decode
    // ============================
    assign access = psel_i && penable_i;
    assign wr_en  = access && pwrite_i;
    assign rd_en  = access && !pwrite_i;

    always_comb begin
        case (paddr_i)
            REG_CTRL, REG_OPU, REG_OPV, REG_OPW,
            REG_CMD, REG_STATUS, REG_RES0, REG_RES1: addr_mapped = 1'b1;
            default: addr_mapped = 1'b0;
        endcase
    end

    assign addr_operand = (paddr_i == REG_OPU) || (paddr_i == REG_OPV) || (paddr_i == REG_OPW);
    assign operand_bad  = (|pwdata_i[31:COEFF_W]) || (pwdata_i[COEFF_W-1:0] >= NTT_Q);
    assign wr_reject    = addr_operand && operand_bad;

    assign pready_o  = 1'b1;
    assign pslverr_o = access && (!addr_mapped || (pwrite_i && wr_reject));

    assign cmd_issue = wr_en && (paddr_i == REG_CMD) && pwdata_i[0];
    assign capture   = valid_pipe[BFLY_LATENCY-1];
    assign busy      = |valid_pipe;

    // ============================
    // Writable registers
    // ============================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mode_q <= ct;
            acc_q  <= 1'b0;
            opu_q  <= '0;
            opv_q  <= '0;
            opw_q  <= '0;
        end else if (wr_en && !wr_reject) begin
            case (paddr_i)
                REG_CTRL: begin
                    mode_q <= mode_t'(pwdata_i[2:0]);
                    acc_q  <= pwdata_i[3];
                end
                REG_OPU: opu_q <= pwdata_i[COEFF_W-1:0];
                REG_OPV: opv_q <= pwdata_i[COEFF_W-1:0];
                REG_OPW: opw_q <= pwdata_i[COEFF_W-1:0];
                default: ;
            endcase
        end
    end

    // Valid pipe, done flag and result capture
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_pipe <= '0;
            done_q     <= 1'b0;
            res0_q     <= '0;
            res1_q     <= '0;
        end else begin
            valid_pipe <= {valid_pipe[BFLY_LATENCY-2:0], cmd_issue};
            // A new launch wins over a capture in the same cycle
            if (cmd_issue) begin
                done_q <= 1'b0;
            end else if (capture) begin
                done_q <= 1'b1;
            end
            if (capture) begin
                res0_q <= res0_i;
                res1_q <= res1_i;
            end
        end
    end

    // ============================
    // Read data
    // ============================
    always_comb begin
        case (paddr_i)
            REG_CTRL:   rdata = apb_data_t'({acc_q, mode_q});
            REG_OPU:    rdata = apb_data_t'(opu_q);
            REG_OPV:    rdata = apb_data_t'(opv_q);
            REG_OPW:    rdata = apb_data_t'(opw_q);
            REG_STATUS: rdata = apb_data_t'({done_q, busy});
            REG_RES0:   rdata = apb_data_t'(res0_q);
            REG_RES1:   rdata = apb_data_t'(res1_q);
            default:    rdata = '0;
        endcase
    end

    assign prdata_o = rd_en ? rdata : '0;

    assign mode_o       = mode_q;
    assign accumulate_o = acc_q;
    assign opu_o        = opu_q;
    assign opv_o        = opv_q;
    assign opw_o        = opw_q;
    assign issue_o      = cmd_issue;

endmodule

`default_nettype wire

/* ntt_butterfly.sv */
// ============================
// Five-mode NTT butterfly, results four cycles after issue in every mode
// gs uses the multiplier one cycle later than ct and pwm, so a gs issue
// directly followed by a ct or pwm issue collides (APB spaces issues by 2)
// ============================
`default_nettype none

module ntt_butterfly
    import ntt_pkg::*;
(
    input  wire    clk,
    input  wire    reset_n,
    input  logic   issue_i,
    input  mode_t  mode_i,
    input  logic   accumulate_i,
    input  coeff_t opu_i,
    input  coeff_t opv_i,
    input  coeff_t opw_i,
    output coeff_t res0_o,
    output coeff_t res1_o
);

    // Control delay lines
    logic  issue_d1;
    mode_t mode_d1, mode_d2, mode_d3, mode_d4;
    logic  acc_d1, acc_d2, acc_d3;

    // Operand delay lines
    coeff_t u_d1, u_d2, u_d3;
    coeff_t v_d1, v_d2, v_d3;
    coeff_t w_d1, w_d2, w_d3;

    // Pre-stage difference and its delayed copies for pws
    coeff_t diff_q1, diff_half;
    coeff_t diff_d2, diff_d3, diff_d4;

    coeff_t mul_opa, mul_opb, mul_res;
    coeff_t add_opa, add_opb, add_res, sub_res;
    logic   gs_mul_slot;

    // x/2 mod q, odd values get q added first
    function automatic coeff_t halve_mod(input coeff_t x);
        logic [COEFF_W:0] t;
        t = x[0] ? ({1'b0, x} + {1'b0, NTT_Q}) : {1'b0, x};
        return t[COEFF_W:1];
    endfunction

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            issue_d1 <= 1'b0;
            mode_d1  <= ct;
            mode_d2  <= ct;
            mode_d3  <= ct;
            mode_d4  <= ct;
            acc_d1   <= 1'b0;
            acc_d2   <= 1'b0;
            acc_d3   <= 1'b0;
        end else begin
            issue_d1 <= issue_i;
            mode_d1  <= mode_i;
            mode_d2  <= mode_d1;
            mode_d3  <= mode_d2;
            mode_d4  <= mode_d3;
            acc_d1   <= accumulate_i;
            acc_d2   <= acc_d1;
            acc_d3   <= acc_d2;
        end
    end

    always_ff @(posedge clk) begin
        u_d1    <= opu_i;
        u_d2    <= u_d1;
        u_d3    <= u_d2;
        v_d1    <= opv_i;
        v_d2    <= v_d1;
        v_d3    <= v_d2;
        w_d1    <= opw_i;
        w_d2    <= w_d1;
        w_d3    <= w_d2;
        diff_d2 <= diff_q1;
        diff_d3 <= diff_d2;
        diff_d4 <= diff_d3;
    end

    // ============================
    // Stage 0 and 1, pre-subtract and multiplier feed
    // ============================
    ntt_add_sub_mod pre_sub_inst (
        .clk     (clk),
        .reset_n (reset_n),
        .sub_i   (1'b1),
        .opa_i   (opu_i),
        .opb_i   (opv_i),
        .res_o   (diff_q1)
    );

    assign diff_half   = halve_mod(diff_q1);
    assign gs_mul_slot = issue_d1 && (mode_d1 == gs);

    // gs enters the multiplier at stage 1 with (u-v)/2 and w
    always_comb begin
        if (gs_mul_slot) begin
            mul_opa = diff_half;
            mul_opb = w_d1;
        end else if (mode_i == pwm) begin
            mul_opa = opu_i;
            mul_opb = opv_i;
        end else begin
            mul_opa = opv_i;
            mul_opb = opw_i;
        end
    end

    ntt_mult_reduction mul_inst (
        .clk     (clk),
        .reset_n (reset_n),
        .opa_i   (mul_opa),
        .opb_i   (mul_opb),
        .res_o   (mul_res)
    );

    // ============================
    // Stage 3, post add and subtract
    // ============================
    always_comb begin
        case (mode_d3)
            ct: begin
                add_opa = u_d3;
                add_opb = mul_res;
            end
            gs, pwa: begin
                add_opa = u_d3;
                add_opb = v_d3;
            end
            pwm: begin
                add_opa = acc_d3 ? w_d3 : '0;
                add_opb = mul_res;
            end
            default: begin
                add_opa = '0;
                add_opb = '0;
            end
        endcase
    end

    ntt_add_sub_mod post_add_inst (
        .clk     (clk),
        .reset_n (reset_n),
        .sub_i   (1'b0),
        .opa_i   (add_opa),
        .opb_i   (add_opb),
        .res_o   (add_res)
    );

    // Only ct reads this result
    ntt_add_sub_mod post_sub_inst (
        .clk     (clk),
        .reset_n (reset_n),
        .sub_i   (1'b1),
        .opa_i   (u_d3),
        .opb_i   (mul_res),
        .res_o   (sub_res)
    );

    // Output select by the mode that travelled with the operands
    always_comb begin
        res0_o = '0;
        res1_o = '0;
        case (mode_d4)
            ct: begin
                res0_o = add_res;
                res1_o = sub_res;
            end
            gs: begin
                res0_o = halve_mod(add_res);
                res1_o = mul_res;
            end
            pwm, pwa: res0_o = add_res;
            pws:      res0_o = diff_d4;
            default: begin
                res0_o = '0;
                res1_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* ntt_butterfly_top.sv */
// ============================
// Butterfly unit behind an APB3 slave
// Issues are at least two cycles apart, one per APB write
// ============================
`default_nettype none

module ntt_butterfly_top
    import ntt_pkg::*;
(
    input  wire       clk,
    input  wire       reset_n,
    input  apb_addr_t paddr_i,
    input  logic      psel_i,
    input  logic      penable_i,
    input  logic      pwrite_i,
    input  apb_data_t pwdata_i,
    output apb_data_t prdata_o,
    output logic      pready_o,
    output logic      pslverr_o
);

    mode_t  mode;
    logic   accumulate;
    logic   issue;
    coeff_t opu, opv, opw;
    coeff_t res0, res1;

    ntt_apb_regs regs_inst (
        .clk          (clk),
        .reset_n      (reset_n),
        .paddr_i      (paddr_i),
        .psel_i       (psel_i),
        .penable_i    (penable_i),
        .pwrite_i     (pwrite_i),
        .pwdata_i     (pwdata_i),
        .prdata_o     (prdata_o),
        .pready_o     (pready_o),
        .pslverr_o    (pslverr_o),
        .mode_o       (mode),
        .accumulate_o (accumulate),
        .opu_o        (opu),
        .opv_o        (opv),
        .opw_o        (opw),
        .issue_o      (issue),
        .res0_i       (res0),
        .res1_i       (res1)
    );

    ntt_butterfly bfly_inst (
        .clk          (clk),
        .reset_n      (reset_n),
        .issue_i      (issue),
        .mode_i       (mode),
        .accumulate_i (accumulate),
        .opu_i        (opu),
        .opv_i        (opv),
        .opw_i        (opw),
        .res0_o       (res0),
        .res1_o       (res1)
    );

endmodule

`default_nettype wire

/* ntt_mult_reduction.sv */
// ============================
// Three-stage 23x23 multiply with reduction modulo q
// Operands must be below q, a new pair is accepted every cycle
// ============================
`default_nettype none

module ntt_mult_reduction
    import ntt_pkg::*;
(
    input  wire    clk,
    input  wire    reset_n,
    input  coeff_t opa_i,
    input  coeff_t opb_i,
    output coeff_t res_o
);

    // Folding uses 2^23 = 2^13 - 1 (mod q)
    prod_t       prod_q;
    logic [36:0] fold1;
    logic [36:0] fold1_q;
    logic [13:0] hi2;
    logic [27:0] fold2;
    logic [4:0]  hi3;
    logic [23:0] fold3;
    logic [23:0] fold3_corr;
    coeff_t      res_d;

    // ============================
    // Stage 2 logic, first fold
    // ============================
    // Product high half is below 2^23, result stays under 2^37
    always_comb begin
        fold1 = 37'({prod_q[45:23], 13'b0})
              + 37'(prod_q[22:0])
              - 37'(prod_q[45:23]);
    end

    // ============================
    // Stage 3 logic, two more folds and final correction
    // ============================
    always_comb begin
        hi2   = fold1_q[36:23];
        fold2 = 28'({hi2, 13'b0}) + 28'(fold1_q[22:0]) - 28'(hi2);

        hi3   = fold2[27:23];
        // Below 2^23 + 2^18, so under 2q
        fold3 = 24'({hi3, 13'b0}) + 24'(fold2[22:0]) - 24'(hi3);

        fold3_corr = fold3 - {1'b0, NTT_Q};
        res_d = (fold3 >= {1'b0, NTT_Q}) ? fold3_corr[COEFF_W-1:0] : fold3[COEFF_W-1:0];
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            prod_q  <= '0;
            fold1_q <= '0;
            res_o   <= '0;
        end else begin
            prod_q  <= prod_t'(opa_i) * prod_t'(opb_i);
            fold1_q <= fold1;
            res_o   <= res_d;
        end
    end

endmodule

`default_nettype wire

/* ntt_pkg.sv */
// ============================
// Shared widths, modulus, mode encoding and APB register map
// Single prime q = 8380417, coefficients are 23 bits wide
// ============================
`default_nettype none

package ntt_pkg;

    // ============================
    // Data widths
    // ============================
    localparam int COEFF_W = 23;

    typedef logic [COEFF_W-1:0]   coeff_t;
    typedef logic [2*COEFF_W-1:0] prod_t;

    // ML-DSA prime, q = 2^23 - 2^13 + 1
    localparam coeff_t NTT_Q = 23'd8380417;

    // Butterfly modes, values match CTRL bits 2..0
    typedef enum logic [2:0] {
        ct  = 3'd0,
        gs  = 3'd1,
        pwm = 3'd2,
        pwa = 3'd3,
        pws = 3'd4
    } mode_t;

    // Issue to result, identical for every mode
    localparam int BFLY_LATENCY = 4;

    // ============================
    // APB register map
    // ============================
    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    localparam apb_addr_t REG_CTRL   = 8'h00;
    localparam apb_addr_t REG_OPU    = 8'h04;
    localparam apb_addr_t REG_OPV    = 8'h08;
    localparam apb_addr_t REG_OPW    = 8'h0C;
    localparam apb_addr_t REG_CMD    = 8'h10;
    localparam apb_addr_t REG_STATUS = 8'h14;
    localparam apb_addr_t REG_RES0   = 8'h18;
    localparam apb_addr_t REG_RES1   = 8'h1C;

endpackage

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and grade the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f compile.f --top-module tb_ntt_butterfly -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: FAIL" "$LOG"; then
    exit 1
fi
exit 0

/* tb_ntt_butterfly.sv */
// ==============================
// Testbench for the APB butterfly unit
// Expected values come from a 64-bit model of the mode rules
// Operands are drawn below q from a fixed-seed LCG
// ==============================
`default_nettype none

module tb_ntt_butterfly
    import ntt_pkg::*;
();

    localparam int     CLK_PERIOD = 40;
    localparam int     N_RAND     = 40;
    localparam int     N_PW       = 3;
    // ct and gs runs, four point-wise cases, two timing launches, three chained launches
    localparam int     NUM_OPS    = 2 * N_RAND + 4 * N_PW + 5;
    localparam int     MARGIN     = 1000 * CLK_PERIOD;
    localparam int     POLL_MAX   = 4 * BFLY_LATENCY;
    localparam coeff_t Q_M1       = NTT_Q - 23'd1;

    logic      clk;
    logic      reset_n;
    apb_addr_t paddr;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_data_t pwdata;
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;

    int          edge_cnt    = 0;
    logic [31:0] lcg_state   = 32'h9c4f71c5;
    logic [3:0]  ctrl_shadow = 4'h0;
    string       cur_test;
    int          test_errs;
    int          pass_cnt    = 0;
    int          fail_cnt    = 0;

    ntt_butterfly_top ntt_butterfly_top_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .paddr_i   (paddr),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .pwdata_i  (pwdata),
        .prdata_o  (prdata),
        .pready_o  (pready),
        .pslverr_o (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Rising edges seen so far, read only between edges
    always @(posedge clk) begin
        edge_cnt <= edge_cnt + 1;
    end

    // ==============================
    // Stimulus and reference model
    // ==============================
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic rand_coeff(output coeff_t c);
        lcg_state = lcg_next(lcg_state);
        c = coeff_t'((lcg_state >> 4) % 32'(NTT_Q));
    endtask

    // Odd values get q added before the shift
    function automatic longint unsigned halve_ref(input longint unsigned x);
        longint unsigned qq;
        qq = 64'(NTT_Q);
        if ((x & 64'd1) != 64'd0) begin
            return (x + qq) / 64'd2;
        end
        return x / 64'd2;
    endfunction

    task automatic model_op(input mode_t mode, input logic acc, input coeff_t u, v, w,
                            output apb_data_t r0, output apb_data_t r1);
        longint unsigned qq;
        longint unsigned uu;
        longint unsigned vv;
        longint unsigned ww;
        longint unsigned t;
        qq = 64'(NTT_Q);
        uu = 64'(u);
        vv = 64'(v);
        ww = 64'(w);
        r1 = '0;
        case (mode)
            ct: begin
                t  = (ww * vv) % qq;
                r0 = apb_data_t'((uu + t) % qq);
                r1 = apb_data_t'((uu + qq - t) % qq);
            end
            gs: begin
                r0 = apb_data_t'(halve_ref((uu + vv) % qq));
                r1 = apb_data_t'((ww * halve_ref((uu + qq - vv) % qq)) % qq);
            end
            pwm:     r0 = apb_data_t'((uu * vv + (acc ? ww : 64'd0)) % qq);
            pwa:     r0 = apb_data_t'((uu + vv) % qq);
            default: r0 = apb_data_t'((uu + qq - vv) % qq);
        endcase
    endtask

    // ==============================
    // Checking and reporting
    // ==============================
    task automatic check_value(input string what, input apb_data_t exp, input apb_data_t act);
        assert (act == exp) else begin
            $display("ERR %s %s expected 0x%0h actual 0x%0h", cur_test, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic begin_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        if (test_errs == 0) begin
            pass_cnt++;
            $display("test %s: passed", cur_test);
        end else begin
            fail_cnt++;
            $display("test %s: failed with %0d errors", cur_test, test_errs);
        end
    endtask

    // ==============================
    // APB access
    // ==============================
    // Returns mid access phase, the next edge ends it, so finish a burst with bus_idle
    task automatic apb_xfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                            output apb_data_t rdata, output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        rdata = prdata;
        err   = pslverr;
        check_value("pready", 32'd1, apb_data_t'(pready));
    endtask

    task automatic bus_idle();
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic write_ok(input apb_addr_t addr, input apb_data_t data);
        apb_data_t rd;
        logic      err;
        apb_xfer(1'b1, addr, data, rd, err);
        check_value($sformatf("pslverr on write to 0x%0h", addr), 32'd0, apb_data_t'(err));
    endtask

    task automatic read_ok(input apb_addr_t addr, output apb_data_t data);
        logic err;
        apb_xfer(1'b0, addr, '0, data, err);
        check_value($sformatf("pslverr on read of 0x%0h", addr), 32'd0, apb_data_t'(err));
    endtask

    task automatic write_ctrl(input mode_t mode, input logic acc);
        logic [3:0] ctrl;
        ctrl = {acc, mode};
        write_ok(REG_CTRL, apb_data_t'(ctrl));
        ctrl_shadow = ctrl;
    endtask

    task automatic wait_done();
        apb_data_t st;
        int        n;
        st = '0;
        n  = 0;
        while (st[1] == 1'b0 && n < POLL_MAX) begin
            read_ok(REG_STATUS, st);
            n++;
        end
        if (st[1] == 1'b0) begin
            $display("%s: done not seen after %0d status reads", cur_test, n);
            test_errs++;
        end
    endtask

    task automatic run_op(input mode_t mode, input logic acc, input coeff_t u, v, w);
        apb_data_t exp0;
        apb_data_t exp1;
        apb_data_t got;
        model_op(mode, acc, u, v, w, exp0, exp1);
        write_ok(REG_OPU, apb_data_t'(u));
        write_ok(REG_OPV, apb_data_t'(v));
        write_ok(REG_OPW, apb_data_t'(w));
        if ({acc, mode} != ctrl_shadow) begin
            write_ctrl(mode, acc);
        end
        write_ok(REG_CMD, 32'd1);
        wait_done();
        read_ok(REG_RES0, got);
        check_value($sformatf("res0 u=%0h v=%0h w=%0h", u, v, w), exp0, got);
        read_ok(REG_RES1, got);
        check_value($sformatf("res1 u=%0h v=%0h w=%0h", u, v, w), exp1, got);
        bus_idle();
    endtask

    // ==============================
    // Tests
    // ==============================
    task automatic test_reset();
        apb_data_t d;
        begin_test("reset");
        read_ok(REG_STATUS, d);
        check_value("status", 32'd0, d);
        read_ok(REG_RES0, d);
        check_value("res0", 32'd0, d);
        read_ok(REG_RES1, d);
        check_value("res1", 32'd0, d);
        bus_idle();
        end_test();
    endtask

    task automatic test_random(input mode_t mode, input string name);
        coeff_t u;
        coeff_t v;
        coeff_t w;
        begin_test(name);
        for (int i = 0; i < N_RAND; i++) begin
            case (i)
                0: begin
                    u = '0;
                    v = '0;
                    w = '0;
                end
                1: begin
                    u = Q_M1;
                    v = Q_M1;
                    w = Q_M1;
                end
                // Odd sum and odd difference
                2: begin
                    u = 23'd1;
                    v = '0;
                    w = Q_M1;
                end
                3: begin
                    u = '0;
                    v = Q_M1;
                    rand_coeff(w);
                end
                default: begin
                    rand_coeff(u);
                    rand_coeff(v);
                    rand_coeff(w);
                end
            endcase
            run_op(mode, 1'b0, u, v, w);
        end
        end_test();
    endtask

    task automatic test_pointwise();
        coeff_t u;
        coeff_t v;
        coeff_t w;
        begin_test("pointwise");
        for (int i = 0; i < 4 * N_PW; i++) begin
            rand_coeff(u);
            rand_coeff(v);
            rand_coeff(w);
            case (i % 4)
                0:       run_op(pwm, 1'b0, u, v, w);
                1:       run_op(pwm, 1'b1, u, v, w);
                2:       run_op(pwa, 1'b0, u, v, w);
                default: run_op(pws, 1'b0, u, v, w);
            endcase
        end
        end_test();
    endtask

    // The two runs sample status on odd and even edges after the launch edge
    task automatic test_timing();
        apb_data_t st;
        apb_data_t exp_st;
        int        cmd_end;
        int        d;
        begin_test("done timing");
        for (int gap = 0; gap < 2; gap++) begin
            write_ok(REG_CMD, 32'd1);
            cmd_end = edge_cnt + 1;
            if (gap == 1) begin
                bus_idle();
            end
            for (int k = 0; k < 4; k++) begin
                read_ok(REG_STATUS, st);
                d      = edge_cnt - cmd_end;
                exp_st = (d >= BFLY_LATENCY) ? 32'd2 : 32'd1;
                check_value($sformatf("status %0d edges after launch", d), exp_st, st);
            end
            bus_idle();
        end
        end_test();
    endtask

    task automatic test_chain();
        coeff_t    u1;
        coeff_t    v1;
        coeff_t    w1;
        coeff_t    u2;
        apb_data_t exp0;
        apb_data_t exp1;
        apb_data_t got;
        begin_test("back-to-back");
        rand_coeff(u1);
        rand_coeff(v1);
        rand_coeff(w1);
        rand_coeff(u2);
        if (u2 == u1) begin
            u2 = (u1 == Q_M1) ? 23'd0 : u1 + 23'd1;
        end
        model_op(gs, 1'b0, u2, v1, w1, exp0, exp1);
        write_ok(REG_OPU, apb_data_t'(u1));
        write_ok(REG_OPV, apb_data_t'(v1));
        write_ok(REG_OPW, apb_data_t'(w1));
        write_ctrl(ct, 1'b0);
        // Each launch lands four edges after the previous one, still busy
        write_ok(REG_CMD, 32'd1);
        write_ctrl(gs, 1'b0);
        write_ok(REG_CMD, 32'd1);
        write_ok(REG_OPU, apb_data_t'(u2));
        write_ok(REG_CMD, 32'd1);
        wait_done();
        read_ok(REG_RES0, got);
        check_value("res0 of last launch", exp0, got);
        read_ok(REG_RES1, got);
        check_value("res1 of last launch", exp1, got);
        bus_idle();
        end_test();
    endtask

    task automatic test_errors();
        coeff_t    u;
        apb_data_t d;
        logic      err;
        begin_test("pslverr");
        rand_coeff(u);
        write_ok(REG_OPU, apb_data_t'(u));
        apb_xfer(1'b1, REG_OPU, apb_data_t'(NTT_Q), d, err);
        check_value("pslverr on OPU write of q", 32'd1, apb_data_t'(err));
        apb_xfer(1'b1, REG_OPU, 32'h8000_0001, d, err);
        check_value("pslverr on OPU write with high bits", 32'd1, apb_data_t'(err));
        apb_xfer(1'b0, 8'h20, '0, d, err);
        check_value("pslverr on unmapped read", 32'd1, apb_data_t'(err));
        apb_xfer(1'b1, 8'h24, 32'd1, d, err);
        check_value("pslverr on unmapped write", 32'd1, apb_data_t'(err));
        read_ok(REG_OPU, d);
        check_value("OPU after rejected writes", apb_data_t'(u), d);
        bus_idle();
        end_test();
    endtask

    // ==============================
    // Main sequence and watchdog
    // ==============================
    initial begin
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= '0;
        pwdata  <= '0;
        reset_n <= 1'b0;
        repeat (4) @(posedge clk);
        reset_n <= 1'b1;

        test_reset();
        test_random(ct, "ct random");
        test_random(gs, "gs random");
        test_pointwise();
        test_timing();
        test_chain();
        test_errors();

        $display("tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        #(NUM_OPS * 20 * CLK_PERIOD + MARGIN);
        $display("watchdog expired before the tests completed");
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
